// ==== logic/vera_pkg.sv ====
`default_nettype none

package vera_pkg;

	typedef logic [16:0] wb_addr_t;   // host bus word address
	typedef logic [31:0] wb_data_t;
	typedef logic [5:0]  reg_addr_t;
	typedef logic [7:0]  color_idx_t;
	typedef logic [15:0] pal_entry_t; // low 12 bits hold R, G and B from the top down
	typedef logic [3:0]  vga_color_t;
	typedef logic [9:0]  hcount_t;
	typedef logic [9:0]  vcount_t;    // scanline, irq line and vertical window

	// word address map of the host port
	localparam wb_addr_t REG_SPACE_WORDS = 17'h00400;
	localparam wb_addr_t PAL_WORD_START  = 17'h00800;
	localparam wb_addr_t PAL_WORD_END    = 17'h00900;

	localparam reg_addr_t REG_BORDER     = 6'h01;
	localparam reg_addr_t REG_IRQ_ENABLE = 6'h02;
	localparam reg_addr_t REG_IRQ_STATUS = 6'h03;
	localparam reg_addr_t REG_IRQ_LINE   = 6'h04;
	localparam reg_addr_t REG_SCANLINE   = 6'h05;
	localparam reg_addr_t REG_VIDEO_MODE = 6'h06;
	localparam reg_addr_t REG_HSTART     = 6'h0a;
	localparam reg_addr_t REG_HSTOP      = 6'h0b;
	localparam reg_addr_t REG_VSTART     = 6'h0c;
	localparam reg_addr_t REG_VSTOP      = 6'h0d;

	// output mode field, only VGA drives the pins
	localparam logic [1:0] MODE_VGA = 2'b01;

endpackage

`default_nettype wire

// ==== logic/vera_bus_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_bus_regs #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  cyc_i,
	input  wire logic                  stb_i,
	input  wire logic                  we_i,
	input  wire vera_pkg::wb_addr_t    adr_i,
	input  wire vera_pkg::wb_data_t    dat_i,
	input  wire logic [3:0]            sel_i,
	input  wire vera_pkg::vcount_t     scanline_i,
	input  wire logic                  vblank_pulse_i,
	input  wire logic                  line_irq_i,
	output vera_pkg::wb_data_t         dat_o,
	output logic                       ack_o,
	output logic                       stall_o,
	output logic                       irq_n_o,
	output logic                       pal_we_o,
	output vera_pkg::color_idx_t       pal_addr_o,
	output vera_pkg::pal_entry_t       pal_data_o,
	output logic [1:0]                 pal_sel_o,
	output vera_pkg::color_idx_t       border_o,
	output vera_pkg::vcount_t          irq_line_o,
	output vera_pkg::hcount_t          hstart_o,
	output vera_pkg::hcount_t          hstop_o,
	output vera_pkg::vcount_t          vstart_o,
	output vera_pkg::vcount_t          vstop_o,
	output logic [1:0]                 video_mode_o
);
	import vera_pkg::*;

	logic       ack_r;
	logic       accept;
	logic       is_reg;
	logic       is_pal;
	logic       reg_wr;
	reg_addr_t  reg_idx;
	wb_data_t   rd_data;
	wb_data_t   dat_r;
	logic [1:0] irq_en_r;     // bit 0 vsync, bit 1 line
	logic [1:0] irq_status_r;
	logic [1:0] status_next;
	color_idx_t border_r;
	vcount_t    irq_line_r;
	logic [1:0] mode_r;
	hcount_t    hstart_r;
	hcount_t    hstop_r;
	vcount_t    vstart_r;
	vcount_t    vstop_r;
	logic       pal_we_r;
	color_idx_t pal_addr_r;
	pal_entry_t pal_data_r;
	logic [1:0] pal_sel_r;

	// only one request is in flight, so ack always comes the cycle after
	assign accept  = cyc_i && stb_i && !ack_r;
	assign is_reg  = adr_i < REG_SPACE_WORDS;
	assign is_pal  = (adr_i >= PAL_WORD_START) && (adr_i < PAL_WORD_END);
	assign reg_idx = adr_i[5:0];
	assign reg_wr  = accept && we_i && is_reg;

	// a new event beats a clear written in the same cycle
	always_comb begin
		status_next = irq_status_r;
		if (reg_wr && reg_idx == REG_IRQ_STATUS)
			status_next = irq_status_r & ~dat_i[1:0];
		if (vblank_pulse_i)
			status_next[0] = 1'b1;
		if (line_irq_i)
			status_next[1] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_r        <= 1'b0;
			pal_we_r     <= 1'b0;
			irq_en_r     <= '0;
			irq_status_r <= '0;
			border_r     <= '0;
			irq_line_r   <= '0;
			mode_r       <= '0;
			hstart_r     <= '0;
			hstop_r      <= hcount_t'(H_ACTIVE);
			vstart_r     <= '0;
			vstop_r      <= vcount_t'(V_ACTIVE);
		end else begin
			ack_r        <= accept;
			pal_we_r     <= accept && we_i && is_pal;
			irq_status_r <= status_next;
			if (reg_wr) begin
				case (reg_idx)
					REG_BORDER:     border_r   <= dat_i[7:0];
					REG_IRQ_ENABLE: irq_en_r   <= dat_i[1:0];
					REG_IRQ_LINE:   irq_line_r <= dat_i[9:0];
					REG_VIDEO_MODE: mode_r     <= dat_i[1:0];
					REG_HSTART:     hstart_r   <= dat_i[9:0];
					REG_HSTOP:      hstop_r    <= dat_i[9:0];
					REG_VSTART:     vstart_r   <= dat_i[9:0];
					REG_VSTOP:      vstop_r    <= dat_i[9:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_idx)
			REG_BORDER:     rd_data = wb_data_t'(border_r);
			REG_IRQ_ENABLE: rd_data = wb_data_t'(irq_en_r);
			REG_IRQ_STATUS: rd_data = wb_data_t'(irq_status_r);
			REG_IRQ_LINE:   rd_data = wb_data_t'(irq_line_r);
			REG_SCANLINE:   rd_data = wb_data_t'(scanline_i);
			REG_VIDEO_MODE: rd_data = wb_data_t'(mode_r);
			REG_HSTART:     rd_data = wb_data_t'(hstart_r);
			REG_HSTOP:      rd_data = wb_data_t'(hstop_r);
			REG_VSTART:     rd_data = wb_data_t'(vstart_r);
			REG_VSTOP:      rd_data = wb_data_t'(vstop_r);
			default:        rd_data = '0;
		endcase
	end

	// the payload is captured on accept and shows up together with ack
	always_ff @(posedge clk) begin
		if (accept) begin
			dat_r      <= (!we_i && is_reg) ? rd_data : '0; // palette and unmapped read as 0
			pal_addr_r <= adr_i[7:0];
			pal_data_r <= dat_i[15:0];
			pal_sel_r  <= sel_i[1:0];
		end
	end

	assign dat_o   = dat_r;
	assign ack_o   = ack_r;
	assign stall_o = cyc_i && !ack_r;
	assign irq_n_o = (irq_status_r & irq_en_r) == 2'b00;

	assign pal_we_o   = pal_we_r;
	assign pal_addr_o = pal_addr_r;
	assign pal_data_o = pal_data_r;
	assign pal_sel_o  = pal_sel_r;

	assign border_o     = border_r;
	assign irq_line_o   = irq_line_r;
	assign hstart_o     = hstart_r;
	assign hstop_o      = hstop_r;
	assign vstart_o     = vstart_r;
	assign vstop_o      = vstop_r;
	assign video_mode_o = mode_r;

	// the master keeps cyc up until it has seen ack
	ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack_o |-> cyc_i);

endmodule

`default_nettype wire

// ==== logic/vera_video_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_video_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  wire logic          clk,
	input  wire logic          reset,
	output vera_pkg::hcount_t  hcount_o,
	output vera_pkg::vcount_t  vcount_o,
	output logic               visible_o,
	output logic               hsync_o,
	output logic               vsync_o,
	output logic               line_start_o,
	output logic               vblank_pulse_o
);
	import vera_pkg::*;

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam hcount_t H_LAST     = hcount_t'(H_TOTAL - 1);
	localparam vcount_t V_LAST     = vcount_t'(V_TOTAL - 1);
	localparam hcount_t HS_START   = hcount_t'(H_ACTIVE + H_FRONT);
	localparam hcount_t HS_END     = hcount_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam vcount_t VS_START   = vcount_t'(V_ACTIVE + V_FRONT);
	localparam vcount_t VS_END     = vcount_t'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam hcount_t H_VIS_END  = hcount_t'(H_ACTIVE);
	localparam vcount_t V_VIS_END  = vcount_t'(V_ACTIVE);

	hcount_t h_cnt;
	vcount_t v_cnt;

	// one pixel per clock
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign hcount_o  = h_cnt;
	assign vcount_o  = v_cnt;
	assign visible_o = (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);

	// both syncs are active low
	assign hsync_o = !((h_cnt >= HS_START) && (h_cnt < HS_END));
	assign vsync_o = !((v_cnt >= VS_START) && (v_cnt < VS_END));

	assign line_start_o   = h_cnt == '0;
	assign vblank_pulse_o = (h_cnt == '0) && (v_cnt == V_VIS_END); // first line after the picture

	h_in_range: assert property (@(posedge clk) disable iff (reset)
		(h_cnt < hcount_t'(H_TOTAL)) && (v_cnt < vcount_t'(V_TOTAL)));

endmodule

`default_nettype wire

// ==== logic/vera_composer.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_composer (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire vera_pkg::hcount_t     hcount_i,
	input  wire vera_pkg::vcount_t     vcount_i,
	input  wire logic                  visible_i,
	input  wire logic                  hsync_i,
	input  wire logic                  vsync_i,
	input  wire logic                  line_start_i,
	input  wire vera_pkg::color_idx_t  border_i,
	input  wire vera_pkg::vcount_t     irq_line_i,
	input  wire vera_pkg::hcount_t     hstart_i,
	input  wire vera_pkg::hcount_t     hstop_i,
	input  wire vera_pkg::vcount_t     vstart_i,
	input  wire vera_pkg::vcount_t     vstop_i,
	output vera_pkg::color_idx_t       color_idx_o,
	output logic                       visible_o,
	output logic                       hsync_o,
	output logic                       vsync_o,
	output logic                       line_irq_o
);
	import vera_pkg::*;

	logic       in_window;
	color_idx_t idx_r;
	logic       visible_r;
	logic       hsync_r;
	logic       vsync_r;
	logic       line_irq_r;

	assign in_window = (hcount_i >= hstart_i) && (hcount_i < hstop_i) &&
		(vcount_i >= vstart_i) && (vcount_i < vstop_i);

	// with no layers the window itself shows palette entry 0
	always_ff @(posedge clk)
		idx_r <= in_window ? color_idx_t'(0) : border_i;

	always_ff @(posedge clk) begin
		if (reset) begin
			visible_r  <= 1'b0;
			hsync_r    <= 1'b1; // syncs idle high
			vsync_r    <= 1'b1;
			line_irq_r <= 1'b0;
		end else begin
			visible_r  <= visible_i;
			hsync_r    <= hsync_i;
			vsync_r    <= vsync_i;
			line_irq_r <= line_start_i && (vcount_i == irq_line_i);
		end
	end

	assign color_idx_o = idx_r;
	assign visible_o   = visible_r;
	assign hsync_o     = hsync_r;
	assign vsync_o     = vsync_r;
	assign line_irq_o  = line_irq_r;

endmodule

`default_nettype wire

// ==== logic/vera_palette_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_palette_out (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  pal_we_i,
	input  wire vera_pkg::color_idx_t  pal_addr_i,
	input  wire vera_pkg::pal_entry_t  pal_data_i,
	input  wire logic [1:0]            pal_sel_i,
	input  wire vera_pkg::color_idx_t  color_idx_i,
	input  wire logic                  visible_i,
	input  wire logic                  hsync_i,
	input  wire logic                  vsync_i,
	input  wire logic [1:0]            video_mode_i,
	output vera_pkg::vga_color_t       vga_r_o,
	output vera_pkg::vga_color_t       vga_g_o,
	output vera_pkg::vga_color_t       vga_b_o,
	output logic                       vga_hsync_o,
	output logic                       vga_vsync_o
);
	import vera_pkg::*;

	pal_entry_t pal_mem [256];
	pal_entry_t rgb_q;
	logic       visible_q;
	logic       hsync_q;
	logic       vsync_q;

	always_ff @(posedge clk) begin
		if (pal_we_i && pal_sel_i[0])
			pal_mem[pal_addr_i][7:0] <= pal_data_i[7:0];
		if (pal_we_i && pal_sel_i[1])
			pal_mem[pal_addr_i][15:8] <= pal_data_i[15:8];
		rgb_q <= pal_mem[color_idx_i];
	end

	// syncs follow the lookup so they stay lined up with the colour
	always_ff @(posedge clk) begin
		if (reset) begin
			visible_q <= 1'b0;
			hsync_q   <= 1'b1;
			vsync_q   <= 1'b1;
		end else begin
			visible_q <= visible_i;
			hsync_q   <= hsync_i;
			vsync_q   <= vsync_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || video_mode_i != MODE_VGA) begin
			vga_r_o     <= '0;
			vga_g_o     <= '0;
			vga_b_o     <= '0;
			vga_hsync_o <= 1'b0;
			vga_vsync_o <= 1'b0;
		end else begin
			vga_r_o     <= visible_q ? rgb_q[11:8] : '0; // black in the blanking interval
			vga_g_o     <= visible_q ? rgb_q[7:4] : '0;
			vga_b_o     <= visible_q ? rgb_q[3:0] : '0;
			vga_hsync_o <= hsync_q;
			vga_vsync_o <= vsync_q;
		end
	end

endmodule

`default_nettype wire

// ==== logic/vera_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_top #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                cyc_i,
	input  wire logic                stb_i,
	input  wire logic                we_i,
	input  wire vera_pkg::wb_addr_t  adr_i,
	input  wire vera_pkg::wb_data_t  dat_i,
	input  wire logic [3:0]          sel_i,
	output vera_pkg::wb_data_t       dat_o,
	output logic                     ack_o,
	output logic                     stall_o,
	output logic                     irq_n_o,
	output vera_pkg::vga_color_t     vga_r_o,
	output vera_pkg::vga_color_t     vga_g_o,
	output vera_pkg::vga_color_t     vga_b_o,
	output logic                     vga_hsync_o,
	output logic                     vga_vsync_o
);
	import vera_pkg::*;

	logic       pal_we;
	color_idx_t pal_addr;
	pal_entry_t pal_data;
	logic [1:0] pal_sel;
	color_idx_t border;
	vcount_t    irq_line;
	hcount_t    hstart;
	hcount_t    hstop;
	vcount_t    vstart;
	vcount_t    vstop;
	logic [1:0] video_mode;
	hcount_t    hcount;
	vcount_t    vcount;
	logic       tim_visible;
	logic       tim_hsync;
	logic       tim_vsync;
	logic       line_start;
	logic       vblank_pulse;
	color_idx_t comp_idx;
	logic       comp_visible;
	logic       comp_hsync;
	logic       comp_vsync;
	logic       line_irq;

	vera_bus_regs #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE)
	) i_bus_regs (
		.clk(clk),
		.reset(reset),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.sel_i(sel_i),
		.scanline_i(vcount),
		.vblank_pulse_i(vblank_pulse),
		.line_irq_i(line_irq),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.stall_o(stall_o),
		.irq_n_o(irq_n_o),
		.pal_we_o(pal_we),
		.pal_addr_o(pal_addr),
		.pal_data_o(pal_data),
		.pal_sel_o(pal_sel),
		.border_o(border),
		.irq_line_o(irq_line),
		.hstart_o(hstart),
		.hstop_o(hstop),
		.vstart_o(vstart),
		.vstop_o(vstop),
		.video_mode_o(video_mode)
	);

	vera_video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) i_video_timing (
		.clk(clk),
		.reset(reset),
		.hcount_o(hcount),
		.vcount_o(vcount),
		.visible_o(tim_visible),
		.hsync_o(tim_hsync),
		.vsync_o(tim_vsync),
		.line_start_o(line_start),
		.vblank_pulse_o(vblank_pulse)
	);

	vera_composer i_composer (
		.clk(clk),
		.reset(reset),
		.hcount_i(hcount),
		.vcount_i(vcount),
		.visible_i(tim_visible),
		.hsync_i(tim_hsync),
		.vsync_i(tim_vsync),
		.line_start_i(line_start),
		.border_i(border),
		.irq_line_i(irq_line),
		.hstart_i(hstart),
		.hstop_i(hstop),
		.vstart_i(vstart),
		.vstop_i(vstop),
		.color_idx_o(comp_idx),
		.visible_o(comp_visible),
		.hsync_o(comp_hsync),
		.vsync_o(comp_vsync),
		.line_irq_o(line_irq)
	);

	vera_palette_out i_palette_out (
		.clk(clk),
		.reset(reset),
		.pal_we_i(pal_we),
		.pal_addr_i(pal_addr),
		.pal_data_i(pal_data),
		.pal_sel_i(pal_sel),
		.color_idx_i(comp_idx),
		.visible_i(comp_visible),
		.hsync_i(comp_hsync),
		.vsync_i(comp_vsync),
		.video_mode_i(video_mode),
		.vga_r_o(vga_r_o),
		.vga_g_o(vga_g_o),
		.vga_b_o(vga_b_o),
		.vga_hsync_o(vga_hsync_o),
		.vga_vsync_o(vga_vsync_o)
	);

endmodule

`default_nettype wire

// ==== sim/vera_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vera_tb;
	import vera_pkg::*;

	localparam int H_TOTAL = 16 + 2 + 3 + 3;
	localparam int V_TOTAL = 12 + 1 + 2 + 2;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int VBLANK_POS = 12 * H_TOTAL; // first pixel of the line after the picture
	localparam int CYCLES_PER_CMD = 2000;

	logic       clk;
	logic       reset;
	logic       cyc_i;
	logic       stb_i;
	logic       we_i;
	wb_addr_t   adr_i;
	wb_data_t   dat_i;
	logic [3:0] sel_i;
	wb_data_t   dat_o;
	logic       ack_o;
	logic       stall_o;
	logic       irq_n_o;
	vga_color_t vga_r_o;
	vga_color_t vga_g_o;
	vga_color_t vga_b_o;
	logic       vga_hsync_o;
	logic       vga_vsync_o;

	byte         cmd_q[$];
	logic [31:0] arg_a_q[$];
	logic [31:0] arg_b_q[$];
	logic [31:0] arg_c_q[$];
	logic [31:0] arg_d_q[$];
	int          line_q[$];

	int errors;
	int checks;
	int cycle_limit;
	int cycles = 0;
	int frame_pos = 0;

	vera_top #(
		.H_ACTIVE(16),
		.H_FRONT(2),
		.H_SYNC(3),
		.H_BACK(3),
		.V_ACTIVE(12),
		.V_FRONT(1),
		.V_SYNC(2),
		.V_BACK(2)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.sel_i(sel_i),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.stall_o(stall_o),
		.irq_n_o(irq_n_o),
		.vga_r_o(vga_r_o),
		.vga_g_o(vga_g_o),
		.vga_b_o(vga_b_o),
		.vga_hsync_o(vga_hsync_o),
		.vga_vsync_o(vga_vsync_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// tracks the counter position, which steps one pixel per clock from 0,0 after reset
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (reset)
			frame_pos <= 0;
		else
			frame_pos <= (frame_pos == FRAME - 1) ? 0 : frame_pos + 1;
	end

	initial begin
		while (cycle_limit == 0 || cycles <= cycle_limit)
			@(posedge clk);
		$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
		$display("errors: %0d in %0d checks", errors, checks);
		$display("Simulation failed");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input string expected,
		input logic [31:0] actual);
		errors++;
		$display("ERROR %s: expected %s, actual %0h", name, expected, actual);
	endtask

	function automatic string command_name(input byte cmd);
		case (cmd)
			"w": return "write";
			"r": return "read";
			"f": return "frame";
			"i": return "irq";
			default: return "unknown";
		endcase
	endfunction

	// the request is held through the edge that takes ack, then the bus goes idle
	task automatic bus_cycle(input string name, input logic we, input wb_addr_t adr,
		input wb_data_t wdata, output wb_data_t rdata);
		int n;
		n = 0;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = adr;
		dat_i = wdata;
		sel_i = 4'hf;
		#1;
		checks++;
		if (!stall_o) begin
			errors++;
			$display("ERROR %s: stall was low while the request waited", name);
		end
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ack_o && n < 8);
		rdata = dat_o;
		checks++;
		if (!ack_o) begin
			errors++;
			$display("ERROR %s: no ack came for the request", name);
		end else if (n != 1)
			report_mismatch(name, "ack latency 1", n);
		next_cycle();
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	// pins are counted over one whole frame starting at the vblank line
	task automatic count_frame(input string name, input logic [11:0] rgb, input int exp_pix,
		input int exp_hs, input int exp_vs);
		int pix;
		int hs;
		int vs;
		pix = 0;
		hs = 0;
		vs = 0;
		while (frame_pos != VBLANK_POS)
			next_cycle();
		for (int i = 0; i < FRAME; i++) begin
			if ({vga_r_o, vga_g_o, vga_b_o} == rgb)
				pix++;
			if (vga_hsync_o)
				hs++;
			if (vga_vsync_o)
				vs++;
			next_cycle();
		end
		checks += 3;
		if (pix != exp_pix)
			report_mismatch({name, " pixels"}, $sformatf("%0h", exp_pix), pix);
		if (hs != exp_hs)
			report_mismatch({name, " hsync high"}, $sformatf("%0h", exp_hs), hs);
		if (vs != exp_vs)
			report_mismatch({name, " vsync high"}, $sformatf("%0h", exp_vs), vs);
	endtask

	task automatic wait_irq(input string name, input logic level);
		int n;
		n = 0;
		while (irq_n_o != level && n < FRAME) begin
			next_cycle();
			n++;
		end
		checks++;
		if (irq_n_o != level) begin
			errors++;
			$display("ERROR %s: irq_n did not reach %0d within %0d cycles", name, level, n);
		end
	endtask

	task automatic load_commands();
		int fd;
		int code;
		int lineno;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		lineno = 0;
		fd = $fopen("sim/vera_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the command file sim/vera_input.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				lineno++;
				if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
					a = 0;
					b = 0;
					c = 0;
					d = 0;
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
					cmd_q.push_back(line.getc(0));
					arg_a_q.push_back(a);
					arg_b_q.push_back(b);
					arg_c_q.push_back(c);
					arg_d_q.push_back(d);
					line_q.push_back(lineno);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		string name;
		wb_data_t rd;
		errors = 0;
		checks = 0;
		cycle_limit = 0;
		reset = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		adr_i = '0;
		dat_i = '0;
		sel_i = '0;
		load_commands();
		cycle_limit = cmd_q.size() * CYCLES_PER_CMD;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int k = 0; k < cmd_q.size(); k++) begin
			name = $sformatf("%s at line %0d", command_name(cmd_q[k]), line_q[k]);
			case (cmd_q[k])
				"w": bus_cycle(name, 1'b1, arg_a_q[k][16:0], arg_b_q[k], rd);
				"r": begin
					bus_cycle(name, 1'b0, arg_a_q[k][16:0], '0, rd);
					checks++;
					if (rd < arg_b_q[k] || rd > arg_c_q[k])
						report_mismatch(name, $sformatf("%0h..%0h", arg_b_q[k], arg_c_q[k]), rd);
				end
				"f": count_frame(name, arg_a_q[k][11:0], arg_b_q[k], arg_c_q[k], arg_d_q[k]);
				"i": wait_irq(name, arg_a_q[k][0]);
				default: begin
					errors++;
					$display("ERROR %s: the command letter is not known", name);
				end
			endcase
		end
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/vera_input.txt ====
# one command per line, every number in hex
# w addr data, r addr lo hi (data must lie in lo..hi), i level (wait for irq_n)
# f rgb pixels hs vs (one frame: pixels of that RGB, cycles with hsync high, with vsync high)
r 0000a 0 0      # hstart
r 0000b 10 10    # hstop resets to the active width
r 0000c 0 0
r 0000d c c
r 00006 0 0      # mode
r 00002 0 0      # irq enables
w 00002 ffffffff
r 00002 3 3
w 00002 0
w 00001 1ff
r 00001 ff ff
w 00006 ffffffff
r 00006 3 3
w 00006 0
w 0000a ffffffff
r 0000a 3ff 3ff
w 00004 ffffffff
r 00004 3ff 3ff  # line 1023 never comes
r 00805 0 0      # palette reads back 0
r 00420 0 0      # unmapped
w 00805 f0a
w 00800 0c3
w 00001 5
f 000 198 0 0    # mode 0 keeps all 408 samples low
w 00006 1
w 0000a 4
w 0000b c
w 0000c 3
w 0000d 9
f 0c3 30 165 168 # 48 window pixels
f f0a 90 165 168 # 144 border pixels
f 000 d8 165 168 # 216 blanked samples
w 00003 3
w 00002 1
i 0
r 00003 1 1
w 00003 1
i 1
r 00003 0 0
w 00002 0
w 00004 7
w 00002 2
w 00003 3
i 0
r 00005 7 8

// ==== flist.f ====
logic/vera_pkg.sv
logic/vera_bus_regs.sv
logic/vera_video_timing.sv
logic/vera_composer.sv
logic/vera_palette_out.sv
logic/vera_top.sv
sim/vera_tb.sv

// ==== Makefile ====
TOP = vera_tb

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF "Simulation completed successfully"

clean:
	rm -rf obj_dir
